// File: hw/kmcPkg.sv
// KMC11 front end shared constants, bus field positions and pipeline types

`default_nettype none

package kmcPkg;

   ////////////////////////////////////////////////////////////
   // Device identity
   ////////////////////////////////////////////////////////////

   localparam int busWidth     = 36;              // Address and data word width
   localparam int csrWidth     = 16;              // Register word width
   localparam int mntAddrWidth = 10;              // Maintenance address, store depth
   localparam int devWidth     = 4;
   localparam int addrWidth    = 18;

   localparam logic [devWidth-1:0]  kmcDev  = 4'd3;        // Device number
   localparam logic [addrWidth-1:0] kmcAddr = 18'o760540;  // SEL0, others at +2 +4 +6
   localparam logic [csrWidth-1:0]  kmcVect = 16'o300;     // Base interrupt vector

   ////////////////////////////////////////////////////////////
   // Address word layout, little-endian numbering
   ////////////////////////////////////////////////////////////

   localparam int flagRead  = 32;
   localparam int flagWrite = 30;
   localparam int flagPhys  = 27;
   localparam int flagIo    = 25;
   localparam int flagWru   = 24;                 // Who-are-you cycle
   localparam int flagVect  = 23;                 // Interrupt vector read
   localparam int flagByte  = 22;

   localparam int devField  = 18;                 // Device number in bits 21:18
   localparam int addrField = 0;                  // Register address in bits 17:0

   ////////////////////////////////////////////////////////////
   // Maintenance byte (high byte of SEL0)
   ////////////////////////////////////////////////////////////

   localparam int mntRun     = 7;
   localparam int mntMclr    = 6;                 // Self-clearing
   localparam int mntCramWr  = 5;                 // Self-clearing
   localparam int mntCramOut = 4;
   localparam int mntLuStep  = 2;
   localparam int mntLuLoop  = 1;

   // Bits that hold their value once written
   localparam logic [7:0] mntWrMask = 8'((1 << mntRun) | (1 << mntCramOut) |
                                         (1 << mntLuStep) | (1 << mntLuLoop));

   typedef enum logic [1:0] {
      opNone,
      opRead,
      opWrite,
      opVectRead
   } kmcOp_t;

   typedef enum logic [1:0] {
      sel0,
      sel2,
      sel4,
      sel6
   } kmcSel_t;

endpackage

`default_nettype wire

// File: hw/kmcBusDecode.sv
// KMC11 stage 1, decodes a bus request into an operation and a register select

`default_nettype none
`timescale 1ns/1ns

module kmcBusDecode
   import kmcPkg::*;
(
   input  wire logic                clk,
   input  wire logic                rstN,
   input  wire logic                devReq,
   input  wire logic [busWidth-1:0] devAddr,
   input  wire logic [busWidth-1:0] devData,
   output logic                     valid1,
   output kmcOp_t                   op1,
   output kmcSel_t                  sel1,
   output logic                     byteWr1,
   output logic                     hiByte1,
   output logic [csrWidth-1:0]      data1
);

   logic [devWidth-1:0]  reqDev;
   logic [addrWidth-1:0] reqAddr;
   logic                 devHit;                  // Physical IO cycle for this card
   logic                 regHit;                  // One of the four select registers
   kmcOp_t               opNext;

   assign reqDev  = devAddr[devField +: devWidth];
   assign reqAddr = devAddr[addrField +: addrWidth];

   ////////////////////////////////////////////////////////////
   // Request decode
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      devHit = devAddr[flagPhys] && devAddr[flagIo] && !devAddr[flagWru] &&
               (reqDev == kmcDev);
      // Block is octal aligned, bits 2:1 pick the register, bit 0 the byte
      regHit = devHit && !devAddr[flagVect] &&
               (reqAddr[addrWidth-1:3] == kmcAddr[addrWidth-1:3]);
      opNext = opNone;
      if (devHit && devAddr[flagVect] && devAddr[flagRead])
      begin
         opNext = opVectRead;
      end
      else if (regHit && devAddr[flagRead])
      begin
         opNext = opRead;
      end
      else if (regHit && devAddr[flagWrite])
      begin
         opNext = opWrite;
      end
   end

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         valid1  <= 1'b0;
         op1     <= opNone;
         sel1    <= sel0;
         byteWr1 <= 1'b0;
         hiByte1 <= 1'b0;
         data1   <= '0;
      end
      else
      begin
         valid1  <= devReq;
         op1     <= devReq ? opNext : opNone;      // Misses travel as opNone
         sel1    <= kmcSel_t'(reqAddr[2:1]);
         byteWr1 <= devAddr[flagByte];
         hiByte1 <= devAddr[flagByte] && reqAddr[0];
         data1   <= devData[csrWidth-1:0];
      end
   end

endmodule

`default_nettype wire

// File: hw/kmcCsrFile.sv
// KMC11 stage 2, CSR and maintenance byte writes with byte lanes and master clear

`default_nettype none
`timescale 1ns/1ns

module kmcCsrFile
   import kmcPkg::*;
(
   input  wire logic                clk,
   input  wire logic                rstN,
   input  wire logic                devReset,
   input  wire logic                valid1,
   input  kmcOp_t                   op1,
   input  kmcSel_t                  sel1,
   input  wire logic                byteWr1,
   input  wire logic                hiByte1,
   input  wire logic [csrWidth-1:0] data1,
   output logic                     valid2,
   output kmcOp_t                   op2,
   output kmcSel_t                  sel2,
   output logic                     cramOut,
   output logic [7:0]               mntByte,
   output logic [7:0]               csr0Lo,
   output logic [csrWidth-1:0]      csr2,
   output logic [csrWidth-1:0]      csr4,
   output logic [csrWidth-1:0]      csr6,
   output logic                     mntAddrWr,
   output logic                     mntInstWr,
   output logic                     cramWr,
   output logic [csrWidth-1:0]      wrData
);

   logic wrHit;
   logic loLane;
   logic hiLane;
   logic sel0Wr;
   logic mclrSet;                                  // MCLR written this cycle
   logic mclrPend;                                 // Clear runs one cycle later
   logic kmcInit;

   function automatic logic [csrWidth-1:0] mergeLanes(input logic [csrWidth-1:0] oldWord,
                                                      input logic [csrWidth-1:0] newWord,
                                                      input logic lo,
                                                      input logic hi);
      logic [csrWidth-1:0] merged;
      merged = oldWord;
      if (lo)
         merged[7:0] = newWord[7:0];
      if (hi)
         merged[csrWidth-1:8] = newWord[csrWidth-1:8];
      return merged;
   endfunction

   ////////////////////////////////////////////////////////////
   // Write decode and maintenance strobes
   ////////////////////////////////////////////////////////////

   assign wrHit   = valid1 && (op1 == opWrite);
   assign loLane  = !byteWr1 || !hiByte1;
   assign hiLane  = !byteWr1 || hiByte1;
   assign sel0Wr  = wrHit && (sel1 == sel0);
   assign mclrSet = sel0Wr && hiLane && data1[8 + mntMclr];
   assign kmcInit = devReset || mclrPend;
   assign cramOut = mntByte[mntCramOut];

   // CRAMOUT steers SEL4 and SEL6 writes to the maintenance registers
   assign mntAddrWr = wrHit && (sel1 == sel4) && cramOut;
   assign mntInstWr = wrHit && (sel1 == sel6) && cramOut;
   assign cramWr    = sel0Wr && hiLane && data1[8 + mntCramWr];
   assign wrData    = data1;

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         valid2   <= 1'b0;
         op2      <= opNone;
         sel2     <= sel0;
         mclrPend <= 1'b0;
         mntByte  <= '0;
         csr0Lo   <= '0;
         csr2     <= '0;
         csr4     <= '0;
         csr6     <= '0;
      end
      else
      begin
         valid2   <= valid1;
         op2      <= op1;
         sel2     <= sel1;
         mclrPend <= mclrSet;
         if (kmcInit)                              // Maintenance regs and store survive
         begin
            mntByte <= '0;
            csr0Lo  <= '0;
            csr2    <= '0;
            csr4    <= '0;
            csr6    <= '0;
         end
         else
         begin
            if (sel0Wr && loLane)
               csr0Lo <= data1[7:0];
            if (sel0Wr && hiLane)
               mntByte <= data1[csrWidth-1:8] & mntWrMask;   // MCLR, CRAMWR stored as 0
            if (wrHit && (sel1 == kmcPkg::sel2))
               csr2 <= mergeLanes(csr2, data1, loLane, hiLane);
            if (wrHit && (sel1 == sel4) && !cramOut)
               csr4 <= mergeLanes(csr4, data1, loLane, hiLane);
            if (wrHit && (sel1 == sel6) && !cramOut)
               csr6 <= mergeLanes(csr6, data1, loLane, hiLane);
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/kmcCramPort.sv
// KMC11 maintenance address and instruction registers with the 1K word control store

`default_nettype none
`timescale 1ns/1ns

module kmcCramPort
   import kmcPkg::*;
(
   input  wire logic                    clk,
   input  wire logic                    rstN,
   input  wire logic                    mntAddrWr,
   input  wire logic                    mntInstWr,
   input  wire logic                    cramWr,
   input  wire logic [csrWidth-1:0]     wrData,
   output logic      [mntAddrWidth-1:0] mntAddr,
   output logic      [csrWidth-1:0]     cramWord
);

   localparam int cramDepth = 1 << mntAddrWidth;

   logic [csrWidth-1:0] mntInst;                   // Instruction waiting for CRAMWR
   logic [csrWidth-1:0] cram [cramDepth];

   ////////////////////////////////////////////////////////////
   // Maintenance registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         mntAddr <= '0;
         mntInst <= '0;
      end
      else
      begin
         if (mntAddrWr)
            mntAddr <= wrData[mntAddrWidth-1:0];   // Upper SEL4 bits not kept
         if (mntInstWr)
            mntInst <= wrData;
      end
   end

   ////////////////////////////////////////////////////////////
   // Control store
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (cramWr)
         cram[mntAddr] <= mntInst;                 // Address as held before this edge
   end

   // Asynchronous read, seen on SEL6 under CRAMOUT
   assign cramWord = cram[mntAddr];

endmodule

`default_nettype wire

// File: hw/kmcBusResponse.sv
// KMC11 stage 3, read multiplexer with registered acknowledge and read data

`default_nettype none
`timescale 1ns/1ns

module kmcBusResponse
   import kmcPkg::*;
(
   input  wire logic                    clk,
   input  wire logic                    rstN,
   input  wire logic                    valid2,
   input  kmcOp_t                       op2,
   input  kmcSel_t                      sel2,
   input  wire logic                    cramOut,
   input  wire logic [7:0]              mntByte,
   input  wire logic [7:0]              csr0Lo,
   input  wire logic [csrWidth-1:0]     csr2,
   input  wire logic [csrWidth-1:0]     csr4,
   input  wire logic [csrWidth-1:0]     csr6,
   input  wire logic [mntAddrWidth-1:0] mntAddr,
   input  wire logic [csrWidth-1:0]     cramWord,
   output logic                         devAck,
   output logic      [busWidth-1:0]     devDataOut
);

   logic                hit;
   logic                isRead;
   logic [csrWidth-1:0] readWord;

   assign hit    = valid2 && (op2 != opNone);
   assign isRead = valid2 && ((op2 == opRead) || (op2 == opVectRead));

   always_comb
   begin
      case (sel2)
         sel0:          readWord = {mntByte, csr0Lo};
         kmcPkg::sel2:  readWord = csr2;
         sel4:          readWord = cramOut ? {{(csrWidth-mntAddrWidth){1'b0}}, mntAddr} : csr4;
         default:       readWord = cramOut ? cramWord : csr6;
      endcase
      if (op2 == opVectRead)
         readWord = kmcVect;                       // Alternate vector not supported
   end

   ////////////////////////////////////////////////////////////
   // Acknowledge and data out
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         devAck     <= 1'b0;
         devDataOut <= '0;
      end
      else
      begin
         devAck     <= hit;
         devDataOut <= isRead ? {{(busWidth-csrWidth){1'b0}}, readWord} : '0;
      end
   end

endmodule

`default_nettype wire

// File: hw/kmcFrontEnd.sv
// KMC11 programmed-I/O front end, three-stage pipeline from bus request to acknowledge

`default_nettype none
`timescale 1ns/1ns

module kmcFrontEnd
   import kmcPkg::*;
(
   input  wire logic                clk,
   input  wire logic                rstN,
   input  wire logic                devReq,
   input  wire logic [busWidth-1:0] devAddr,
   input  wire logic [busWidth-1:0] devData,
   input  wire logic                devReset,
   output logic                     devAck,
   output logic      [busWidth-1:0] devDataOut,
   output logic                     luStep,
   output logic                     luLoop
);

   // Stage 1 to stage 2
   logic                    valid1;
   kmcOp_t                  op1;
   kmcSel_t                 sel1;
   logic                    byteWr1;
   logic                    hiByte1;
   logic [csrWidth-1:0]     data1;

   // Stage 2 to stage 3
   logic                    valid2;
   kmcOp_t                  op2;
   kmcSel_t                 sel2;
   logic                    cramOut;
   logic [7:0]              mntByte;
   logic [7:0]              csr0Lo;
   logic [csrWidth-1:0]     csr2;
   logic [csrWidth-1:0]     csr4;
   logic [csrWidth-1:0]     csr6;

   // Maintenance side
   logic                    mntAddrWr;
   logic                    mntInstWr;
   logic                    cramWr;
   logic [csrWidth-1:0]     wrData;
   logic [mntAddrWidth-1:0] mntAddr;
   logic [csrWidth-1:0]     cramWord;

   kmcBusDecode uDecode (
      .clk      (clk),
      .rstN     (rstN),
      .devReq   (devReq),
      .devAddr  (devAddr),
      .devData  (devData),
      .valid1   (valid1),
      .op1      (op1),
      .sel1     (sel1),
      .byteWr1  (byteWr1),
      .hiByte1  (hiByte1),
      .data1    (data1)
   );

   kmcCsrFile uCsr (
      .clk       (clk),
      .rstN      (rstN),
      .devReset  (devReset),
      .valid1    (valid1),
      .op1       (op1),
      .sel1      (sel1),
      .byteWr1   (byteWr1),
      .hiByte1   (hiByte1),
      .data1     (data1),
      .valid2    (valid2),
      .op2       (op2),
      .sel2      (sel2),
      .cramOut   (cramOut),
      .mntByte   (mntByte),
      .csr0Lo    (csr0Lo),
      .csr2      (csr2),
      .csr4      (csr4),
      .csr6      (csr6),
      .mntAddrWr (mntAddrWr),
      .mntInstWr (mntInstWr),
      .cramWr    (cramWr),
      .wrData    (wrData)
   );

   kmcCramPort uCram (
      .clk       (clk),
      .rstN      (rstN),
      .mntAddrWr (mntAddrWr),
      .mntInstWr (mntInstWr),
      .cramWr    (cramWr),
      .wrData    (wrData),
      .mntAddr   (mntAddr),
      .cramWord  (cramWord)
   );

   kmcBusResponse uResponse (
      .clk        (clk),
      .rstN       (rstN),
      .valid2     (valid2),
      .op2        (op2),
      .sel2       (sel2),
      .cramOut    (cramOut),
      .mntByte    (mntByte),
      .csr0Lo     (csr0Lo),
      .csr2       (csr2),
      .csr4       (csr4),
      .csr6       (csr6),
      .mntAddr    (mntAddr),
      .cramWord   (cramWord),
      .devAck     (devAck),
      .devDataOut (devDataOut)
   );

   assign luStep = mntByte[mntLuStep];             // Line unit controls
   assign luLoop = mntByte[mntLuLoop];

endmodule

`default_nettype wire

// File: verification/kmcFrontEnd_chk.sv
// KMC11 front end protocol assertions on acknowledge, read data and self-clearing bits

`default_nettype none
`timescale 1ns/1ns

module kmcFrontEnd_chk
   import kmcPkg::*;
(
   input wire logic                clk,
   input wire logic                rstN,
   input wire logic                devReq,
   input wire logic                valid2,
   input kmcOp_t                   op2,
   input kmcSel_t                  sel2,
   input wire logic                devAck,
   input wire logic [busWidth-1:0] devDataOut
);

   // Acknowledge leaves stage 3 three samples after the request
   ackHasReq: assert property (@(posedge clk) disable iff (!rstN)
      devAck |-> $past(devReq, 3))
      else $error("acknowledge without a request three cycles earlier");

   dataIdleZero: assert property (@(posedge clk) disable iff (!rstN)
      !devAck |-> (devDataOut == '0))
      else $error("read data not zero while acknowledge is low");

   // SEL0 read in stage 2 shows its maintenance byte one edge later
   selfClearBits: assert property (@(posedge clk) disable iff (!rstN)
      (valid2 && (op2 == opRead) && (sel2 == sel0)) |=>
         (!devDataOut[8 + mntMclr] && !devDataOut[8 + mntCramWr]))
      else $error("MCLR or CRAMWR read back as 1 from SEL0");

endmodule

bind kmcFrontEnd kmcFrontEnd_chk uChk (.*);

`default_nettype wire

// File: verification/kmcMonitor.sv
// KMC11 response monitor, compares acknowledge and read data with expected responses

`default_nettype none
`timescale 1ns/1ns

module kmcMonitor
   import kmcPkg::*;
(
   input wire logic                clk,
   input wire logic                rstN,
   input wire logic [31:0]         cycle,
   input wire logic                devAck,
   input wire logic [busWidth-1:0] devDataOut
);

   int                  tagQ[$];                   // Cycle that sampled the request
   logic                ackQ[$];
   logic [busWidth-1:0] dataQ[$];
   int                  errorCount = 0;
   int                  checkCount = 0;

   task automatic expectResponse(input int tag, input logic ack, input logic [busWidth-1:0] data);
      tagQ.push_back(tag);
      ackQ.push_back(ack);
      dataQ.push_back(data);
   endtask

   function automatic int pendingCount();
      return tagQ.size();
   endfunction

   task automatic compareLevel(input string name, input logic expVal, input logic actVal);
      checkCount++;
      if (actVal !== expVal)
      begin
         $display("[FAIL] %s: expected %h, got %h", name, expVal, actVal);
         errorCount++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Sampled mid-cycle, away from the driving edge
   ////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      if (tagQ.size() > 0 && tagQ[0] + 3 < cycle)
      begin
         $display("Response slot for the request of cycle %0d was skipped", tagQ[0]);
         errorCount++;
         void'(tagQ.pop_front());
         void'(ackQ.pop_front());
         void'(dataQ.pop_front());
      end
      if (tagQ.size() > 0 && tagQ[0] + 3 == cycle)
      begin
         compareLevel("devAck", ackQ[0], devAck);
         checkCount++;
         if (devDataOut !== dataQ[0])
         begin
            $display("[FAIL] devDataOut: expected %h, got %h (request cycle %0d)",
                     dataQ[0], devDataOut, tagQ[0]);
            errorCount++;
         end
         void'(tagQ.pop_front());
         void'(ackQ.pop_front());
         void'(dataQ.pop_front());
      end
      else if (rstN && devAck !== 1'b0)
      begin
         $display("[FAIL] devAck: expected %h, got %h (no request due)", 1'b0, devAck);
         errorCount++;
      end
   end

endmodule

`default_nettype wire

// File: verification/kmcTb.sv
// KMC11 front end testbench with random register traffic and a reference model

`default_nettype none
`timescale 1ns/1ns

module kmcTb
   import kmcPkg::*;
();

   localparam int timeoutCycles = 100;

   logic                clk;
   logic                rstN;
   logic                devReq;
   logic [busWidth-1:0] devAddr;
   logic [busWidth-1:0] devData;
   logic                devReset;
   logic                devAck;
   logic [busWidth-1:0] devDataOut;
   logic                luStep;
   logic                luLoop;
   int                  cycle = 0;
   logic [31:0]         rngState = 32'd18041;
   int                  testNum = 0;
   int                  lastErrors = 0;
   int                  timeoutCount = 0;

   // Reference model
   logic [7:0]  mCsr0Lo;
   logic [7:0]  mMnt;
   logic [15:0] mCsr2;
   logic [15:0] mCsr4;
   logic [15:0] mCsr6;
   logic [15:0] mInst;
   logic [9:0]  mMntAddr;
   logic [15:0] mCram [1024];

   kmcFrontEnd DUT (.*);

   kmcMonitor uMonitor (
      .clk        (clk),
      .rstN       (rstN),
      .cycle      (cycle),
      .devAck     (devAck),
      .devDataOut (devDataOut)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;
   always @(posedge clk) cycle <= cycle + 1;

   function logic [31:0] nextRandom();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   function automatic logic [busWidth-1:0] busAddr(input logic rd, input logic wr,
                                                   input logic bt, input logic [2:0] offs);
      logic [busWidth-1:0] a;
      a = '0;
      a[flagRead]  = rd;
      a[flagWrite] = wr;
      a[flagPhys]  = 1'b1;
      a[flagIo]    = 1'b1;
      a[flagByte]  = bt;
      a[devField +: devWidth]   = kmcDev;
      a[addrField +: addrWidth] = kmcAddr + {15'b0, offs};
      return a;
   endfunction

   function automatic logic [15:0] laneUpdate(input logic [15:0] old, input logic [15:0] d,
                                              input logic lo, input logic hi);
      logic [15:0] r;
      r = old;
      if (lo)
         r[7:0] = d[7:0];
      if (hi)
         r[15:8] = d[15:8];
      return r;
   endfunction

   function automatic logic [15:0] modelRead(input logic [1:0] sel);
      case (sel)
         2'd0:    return {mMnt, mCsr0Lo};
         2'd1:    return mCsr2;
         2'd2:    return mMnt[mntCramOut] ? {6'b0, mMntAddr} : mCsr4;
         default: return mMnt[mntCramOut] ? mCram[mMntAddr] : mCsr6;
      endcase
   endfunction

   task automatic clearModel();
      mCsr0Lo = '0;
      mMnt    = '0;
      mCsr2   = '0;
      mCsr4   = '0;
      mCsr6   = '0;
   endtask

   task automatic modelWrite(input logic [1:0] sel, input logic lo, input logic hi,
                             input logic [15:0] d);
      logic cOut;
      cOut = mMnt[mntCramOut];
      case (sel)
         2'd0:
         begin
            if (lo)
               mCsr0Lo = d[7:0];
            if (hi)
            begin
               if (d[8 + mntCramWr])
                  mCram[mMntAddr] = mInst;            // Store at the address already held
               mMnt             = '0;               // Only the kept bits hold a value
               mMnt[mntRun]     = d[8 + mntRun];
               mMnt[mntCramOut] = d[8 + mntCramOut];
               mMnt[mntLuStep]  = d[8 + mntLuStep];
               mMnt[mntLuLoop]  = d[8 + mntLuLoop];
               if (d[8 + mntMclr])
                  clearModel();
            end
         end
         2'd1: mCsr2 = laneUpdate(mCsr2, d, lo, hi);
         2'd2:
         begin
            if (cOut)
               mMntAddr = d[9:0];
            else
               mCsr4 = laneUpdate(mCsr4, d, lo, hi);
         end
         default:
         begin
            if (cOut)
               mInst = d;
            else
               mCsr6 = laneUpdate(mCsr6, d, lo, hi);
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Bus requests
   ////////////////////////////////////////////////////////////

   task automatic issue(input logic [busWidth-1:0] addr, input logic [15:0] data,
                        input logic expAck, input logic [15:0] expWord);
      @(posedge clk);
      devReq  <= 1'b1;
      devAddr <= addr;
      devData <= {20'(nextRandom()), data};       // Upper bits are ignored
      uMonitor.expectResponse(cycle + 1, expAck, {20'b0, expWord});
   endtask

   task automatic writeWord(input logic [2:0] offs, input logic [15:0] d);
      issue(busAddr(1'b0, 1'b1, 1'b0, offs), d, 1'b1, 16'h0);
      modelWrite(offs[2:1], 1'b1, 1'b1, d);
   endtask

   task automatic writeByte(input logic [2:0] offs, input logic [15:0] d);
      issue(busAddr(1'b0, 1'b1, 1'b1, offs), d, 1'b1, 16'h0);
      modelWrite(offs[2:1], !offs[0], offs[0], d);
   endtask

   task automatic readWord(input logic [2:0] offs);
      issue(busAddr(1'b1, 1'b0, 1'b0, offs), 16'h0, 1'b1, modelRead(offs[2:1]));
   endtask

   task automatic idleCycle();
      @(posedge clk);
      devReq <= 1'b0;
   endtask

   task automatic endTest(input string name);
      int waited;
      idleCycle();
      waited = 0;
      while (uMonitor.pendingCount() > 0 && waited < timeoutCycles)
      begin
         @(posedge clk);
         waited++;
      end
      testNum++;
      if (uMonitor.pendingCount() > 0)
      begin
         $display("Timeout: %0d responses never arrived in test %s",
                  uMonitor.pendingCount(), name);
         timeoutCount++;
      end
      else
      begin
         $display("Test %0d %s finished, %0d errors", testNum, name,
                  uMonitor.errorCount - lastErrors);
      end
      lastErrors = uMonitor.errorCount;
   endtask

   task automatic pulseReset();
      repeat (3) idleCycle();
      @(posedge clk);
      devReset <= 1'b1;
      @(posedge clk);
      devReset <= 1'b0;
      clearModel();
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      logic [31:0]         r;
      logic [2:0]          offs;
      logic [9:0]          stored [16];
      logic [busWidth-1:0] a;
      devReq   = 1'b0;
      devAddr  = '0;
      devData  = '0;
      devReset = 1'b0;
      rstN     = 1'b0;
      mInst    = '0;
      mMntAddr = '0;
      clearModel();
      repeat (8) @(posedge clk);
      rstN <= 1'b1;
      idleCycle();

      for (int i = 0; i < 48; i++)                // Word traffic on SEL2, SEL4, SEL6
      begin
         r = nextRandom();
         offs = 3'(2 + 2 * (r % 3));
         if (r[8])
            writeWord(offs, 16'(nextRandom()));
         else
            readWord(offs);
      end
      endTest("word access");

      for (int i = 0; i < 40; i++)
      begin
         r = nextRandom();
         offs = 3'(2 + (r % 6));
         if (r[9])
            readWord({offs[2:1], 1'b0});
         else
            writeByte(offs, 16'(nextRandom()));
      end
      readWord(3'd2);
      readWord(3'd4);
      readWord(3'd6);
      endTest("byte lanes");

      writeWord(3'd0, 16'h8fa5);                  // RUN, LUSTEP, LULOOP, unused bits 3 and 0
      readWord(3'd0);
      endTest("maintenance byte");
      uMonitor.compareLevel("luStep", mMnt[mntLuStep], luStep);
      uMonitor.compareLevel("luLoop", mMnt[mntLuLoop], luLoop);
      writeWord(3'd0, 16'h4000);                  // MCLR
      idleCycle();
      readWord(3'd0);
      readWord(3'd2);
      readWord(3'd4);
      readWord(3'd6);
      endTest("master clear");
      uMonitor.compareLevel("luStep", 1'b0, luStep);
      uMonitor.compareLevel("luLoop", 1'b0, luLoop);
      writeWord(3'd2, 16'(nextRandom()));
      writeWord(3'd6, 16'(nextRandom()));
      writeByte(3'd1, 16'h0400);
      endTest("reset preload");
      uMonitor.compareLevel("luStep", mMnt[mntLuStep], luStep);
      uMonitor.compareLevel("luLoop", mMnt[mntLuLoop], luLoop);
      pulseReset();
      readWord(3'd0);
      readWord(3'd2);
      readWord(3'd6);
      endTest("device reset");

      writeWord(3'd2, 16'h1357);
      writeWord(3'd4, 16'h2468);
      writeWord(3'd6, 16'h9abc);
      writeWord(3'd0, 16'h1000);                  // CRAMOUT
      for (int i = 0; i < 16; i++)
      begin
         stored[i] = 10'(nextRandom());
         writeWord(3'd4, {6'(nextRandom()), stored[i]});
         readWord(3'd4);
         writeWord(3'd6, 16'(nextRandom()));
         writeWord(3'd0, 16'h3000);               // CRAMOUT with CRAMWR
         readWord(3'd6);
      end
      readWord(3'd0);
      for (int i = 0; i < 16; i++)
      begin
         writeWord(3'd4, {6'b0, stored[(i * 7) % 16]});
         readWord(3'd6);
      end
      writeWord(3'd0, 16'h0000);
      readWord(3'd2);
      readWord(3'd4);
      readWord(3'd6);
      endTest("control store");

      issue(busAddr(1'b1, 1'b0, 1'b0, 3'd0) | (36'd1 << flagVect), 16'h0, 1'b1, kmcVect);
      a = busAddr(1'b0, 1'b1, 1'b0, 3'd2);
      a[devField +: devWidth] = 4'd5;             // Wrong device
      issue(a, 16'hdead, 1'b0, 16'h0);
      a = busAddr(1'b0, 1'b1, 1'b0, 3'd2);
      a[addrField +: addrWidth] = kmcAddr + 18'd8;
      issue(a, 16'hbeef, 1'b0, 16'h0);
      issue(busAddr(1'b0, 1'b1, 1'b0, 3'd4) | (36'd1 << flagWru), 16'h5555, 1'b0, 16'h0);
      a = busAddr(1'b0, 1'b1, 1'b0, 3'd6);
      a[flagIo] = 1'b0;
      issue(a, 16'haaaa, 1'b0, 16'h0);
      readWord(3'd2);
      readWord(3'd4);
      readWord(3'd6);
      endTest("vector and misses");

      $display("Checks %0d, errors %0d", uMonitor.checkCount,
               uMonitor.errorCount + timeoutCount);
      if (uMonitor.errorCount + timeoutCount == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
hw/kmcPkg.sv
hw/kmcBusDecode.sv
hw/kmcCsrFile.sv
hw/kmcCramPort.sv
hw/kmcBusResponse.sv
hw/kmcFrontEnd.sv
verification/kmcFrontEnd_chk.sv
verification/kmcMonitor.sv
verification/kmcTb.sv

// File: Makefile
# Verilator build and run for the KMC11 front end testbench

VERILATOR ?= verilator
TOP       ?= kmcTb
BUILD     ?= obj_dir
FILELIST  ?= list.f
LOG       ?= sim.log
PASS_TEXT ?= Done: no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
